//--- hw/wb_sim_cfg.svh
/*
 * Simulated Wishbone bus target, configuration macros.
 * Base addresses, window sizes and access latencies of the two RAM
 * windows, plus the trigger word and its interrupt bit positions.
 */
`ifndef WB_SIM_CFG_SVH
`define WB_SIM_CFG_SVH

// data memory window ------------
`define WB_DMEM_BASE    32'h8000_0000  // byte base address
`define WB_DMEM_BYTES   8192           // window size in bytes
`define WB_DMEM_LATENCY 8              // cycles from sampling to ack, min 1

// external IO window ------------
`define WB_XIO_BASE     32'hF000_0000  // start of the IO area
`define WB_XIO_BYTES    32             // kept below one i-cache block
`define WB_XIO_LATENCY  128            // slow device, min 1

// interrupt trigger -------------
`define WB_IRQ_ADDR     32'hFF00_0000  // single trigger word
`define WB_MSI_BIT      3              // write data bit -> machine software irq
`define WB_MEI_BIT      11             // write data bit -> machine external irq

`endif

//--- hw/wb_sim_pkg.sv
/*
 * Simulated Wishbone bus target, shared types.
 * Plain vector typedefs for the classic bus fields that carry
 * a meaning of their own: byte address, data word, byte enables.
 */
`default_nettype none

package wb_sim_pkg;

    // bus field widths --------------
    localparam int WB_ADDR_W = 32;              // byte addressed
    localparam int WB_DATA_W = 32;              // one word per transfer
    localparam int WB_SEL_W  = WB_DATA_W / 8;   // one enable per byte lane

    // bus field types ---------------
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;    // byte address
    typedef logic [WB_DATA_W-1:0] wb_data_t;    // read or write data word
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;     // lane enables, bit 0 = bits 7:0

endpackage : wb_sim_pkg

`default_nettype wire

//--- hw/wb_addr_decode.sv
/*
 * Wishbone address decoder for the simulated bus target.
 * Gates the master strobe to the one target whose range matches
 * and merges the read-back of all targets by OR.
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_cfg.svh"

module wb_addr_decode (
    input  logic                 wb_stb_i,    // master strobe
    input  wb_sim_pkg::wb_addr_t wb_adr_i,    // master byte address
    output logic                 dmem_stb_o,  // strobe to data memory
    output logic                 xio_stb_o,   // strobe to IO window
    output logic                 irq_stb_o,   // strobe to trigger word
    input  wb_sim_pkg::wb_data_t dmem_dat_i,
    input  wb_sim_pkg::wb_data_t xio_dat_i,
    input  wb_sim_pkg::wb_data_t irq_dat_i,
    input  logic                 dmem_ack_i,
    input  logic                 xio_ack_i,
    input  logic                 irq_ack_i,
    output wb_sim_pkg::wb_data_t wb_dat_o,    // merged read data
    output logic                 wb_ack_o     // merged acknowledge
);
    import wb_sim_pkg::*;

    // window bounds -----------------
    localparam wb_addr_t DMEM_LO = `WB_DMEM_BASE;
    localparam wb_addr_t DMEM_HI = `WB_DMEM_BASE + `WB_DMEM_BYTES;  // first byte past window
    localparam wb_addr_t XIO_LO  = `WB_XIO_BASE;
    localparam wb_addr_t XIO_HI  = `WB_XIO_BASE + `WB_XIO_BYTES;
    localparam wb_addr_t IRQ_ADR = `WB_IRQ_ADDR;                   // one word only

    logic dmem_hit;  // address inside data memory
    logic xio_hit;   // address inside IO window
    logic irq_hit;   // exact match on trigger word

    assign dmem_hit = (wb_adr_i >= DMEM_LO) && (wb_adr_i < DMEM_HI);
    assign xio_hit  = (wb_adr_i >= XIO_LO)  && (wb_adr_i < XIO_HI);
    assign irq_hit  = (wb_adr_i == IRQ_ADR);

    // strobe select -----------------
    // an unmapped address raises no strobe, so nobody answers it
    assign dmem_stb_o = wb_stb_i & dmem_hit;
    assign xio_stb_o  = wb_stb_i & xio_hit;
    assign irq_stb_o  = wb_stb_i & irq_hit;

    // read-back merge ---------------
    // targets drive zero while idle, a plain OR replaces a mux
    assign wb_dat_o = dmem_dat_i | xio_dat_i | irq_dat_i;
    assign wb_ack_o = dmem_ack_i | xio_ack_i | irq_ack_i;

endmodule : wb_addr_decode

`default_nettype wire

//--- hw/wb_latency_ram.sv
/*
 * Byte-writable RAM window with a fixed access delay.
 * Writes land on the sampling edge; ack and read data leave
 * through a LATENCY-deep pipeline plus an output register.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_latency_ram #(
    parameter int MEM_BYTES = 8192,  // window size, power of two
    parameter int LATENCY   = 8      // cycles from sampling to ack, min 1
) (
    input  logic                 clk_gen,
    input  logic                 rst_gen,   // async, active low
    input  logic                 cyc_i,     // bus cycle valid
    input  logic                 stb_i,     // decoded strobe
    input  logic                 we_i,      // 1 = write
    input  wb_sim_pkg::wb_addr_t adr_i,     // byte address, word aligned use
    input  wb_sim_pkg::wb_data_t dat_i,     // write data
    input  wb_sim_pkg::wb_sel_t  sel_i,     // byte enables
    output wb_sim_pkg::wb_data_t dat_o,     // zero unless ack
    output logic                 ack_o      // single cycle pulse
);
    import wb_sim_pkg::*;

    localparam int WORDS = MEM_BYTES / 4;                   // 32-bit words
    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1; // word index width

    wb_data_t         mem [WORDS];          // storage array
    logic [IDX_W-1:0] word_idx;             // word select from address
    logic             req;                  // request seen this cycle
    logic [LATENCY-1:0] ack_pipe;           // delayed request flags
    wb_data_t         rdat_pipe [LATENCY];  // delayed read words

    assign word_idx = adr_i[IDX_W+1:2];  // drop byte offset
    assign req      = cyc_i & stb_i;

    // storage -----------------------
    always_ff @(posedge clk_gen) begin
        if (req && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (sel_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= dat_i[b*8 +: 8];  // lane b only
                end
            end
        end
    end

    // delay pipeline ----------------
    // stage 0 reads the word before this edge's write takes effect,
    // so a read-modify pattern sees the old contents
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            ack_pipe <= '0;
            for (int i = 0; i < LATENCY; i++) begin
                rdat_pipe[i] <= '0;
            end
        end else begin
            ack_pipe[0]  <= req;              // first stage needs the strobe
            rdat_pipe[0] <= mem[word_idx];    // old word, write is nonblocking
            for (int i = 1; i < LATENCY; i++) begin
                ack_pipe[i]  <= ack_pipe[i-1] & cyc_i;  // dropped cyc flushes
                rdat_pipe[i] <= rdat_pipe[i-1];
            end
        end
    end

    // bus output register -----------
    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            ack_o <= 1'b0;
            dat_o <= '0;
        end else if (ack_pipe[LATENCY-1] && cyc_i) begin
            ack_o <= 1'b1;                      // request still open, answer it
            dat_o <= rdat_pipe[LATENCY-1];
        end else begin
            ack_o <= 1'b0;
            dat_o <= '0;                        // idle output stays zero for OR merge
        end
    end

endmodule : wb_latency_ram

`default_nettype wire

//--- hw/wb_irq_trigger.sv
/*
 * Interrupt trigger word on the simulated Wishbone target.
 * A full-word write sets the machine software and external
 * interrupt lines from two bits of the write data.
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_cfg.svh"

module wb_irq_trigger (
    input  logic                 clk_gen,
    input  logic                 rst_gen,     // async, active low
    input  logic                 cyc_i,
    input  logic                 stb_i,       // decoded strobe, trigger word only
    input  logic                 we_i,
    input  wb_sim_pkg::wb_sel_t  sel_i,
    input  wb_sim_pkg::wb_data_t dat_i,
    output wb_sim_pkg::wb_data_t dat_o,       // reads as zero
    output logic                 ack_o,       // full-word writes only
    output logic                 msw_irq_o,   // machine software interrupt
    output logic                 mext_irq_o   // machine external interrupt
);
    import wb_sim_pkg::*;

    localparam wb_sel_t SEL_WORD = '1;  // all four lanes

    logic wr_hit;  // full-word write on the bus now
    logic wr_q;    // write sampled, ack due next edge

    assign wr_hit = cyc_i & stb_i & we_i & (sel_i == SEL_WORD);
    assign dat_o  = '0;  // nothing to read back

    always_ff @(posedge clk_gen or negedge rst_gen) begin
        if (!rst_gen) begin
            wr_q       <= 1'b0;
            ack_o      <= 1'b0;
            msw_irq_o  <= 1'b0;
            mext_irq_o <= 1'b0;
        end else begin
            wr_q  <= wr_hit;           // reads and partial writes never get here
            ack_o <= wr_q & cyc_i;     // one cycle after sampling
            if (wr_q && cyc_i) begin   // latch on the ack edge, data still held
                msw_irq_o  <= dat_i[`WB_MSI_BIT];
                mext_irq_o <= dat_i[`WB_MEI_BIT];
            end
        end
    end

endmodule : wb_irq_trigger

`default_nettype wire

//--- hw/wb_sim_target_top.sv
/*
 * Simulated external Wishbone classic target for a RISC-V core.
 * Data memory and IO window with fixed latencies, plus an
 * interrupt trigger word, all behind one address decoder.
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_cfg.svh"

module wb_sim_target_top (
    input  logic                 clk_gen,
    input  logic                 rst_gen,     // async, active low
    input  logic                 wb_cyc_i,    // bus cycle valid
    input  logic                 wb_stb_i,    // transfer strobe
    input  logic                 wb_we_i,     // 1 = write
    input  wb_sim_pkg::wb_addr_t wb_adr_i,    // byte address
    input  wb_sim_pkg::wb_data_t wb_dat_i,    // write data
    input  wb_sim_pkg::wb_sel_t  wb_sel_i,    // byte enables
    output wb_sim_pkg::wb_data_t wb_dat_o,    // read data
    output logic                 wb_ack_o,    // transfer acknowledge
    output logic                 msw_irq_o,   // machine software interrupt
    output logic                 mext_irq_o   // machine external interrupt
);
    import wb_sim_pkg::*;

    // per-target strobes and responses
    logic     dmem_stb, xio_stb, irq_stb;
    wb_data_t dmem_dat, xio_dat, irq_dat;
    logic     dmem_ack, xio_ack, irq_ack;

    // decoder -----------------------
    wb_addr_decode decode_i (
        .wb_stb_i   (wb_stb_i),
        .wb_adr_i   (wb_adr_i),
        .dmem_stb_o (dmem_stb),
        .xio_stb_o  (xio_stb),
        .irq_stb_o  (irq_stb),
        .dmem_dat_i (dmem_dat),
        .xio_dat_i  (xio_dat),
        .irq_dat_i  (irq_dat),
        .dmem_ack_i (dmem_ack),
        .xio_ack_i  (xio_ack),
        .irq_ack_i  (irq_ack),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o)
    );

    // RAM windows -------------------
    wb_latency_ram #(
        .MEM_BYTES (`WB_DMEM_BYTES),
        .LATENCY   (`WB_DMEM_LATENCY)
    ) dmem_i (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .cyc_i   (wb_cyc_i),   // cyc, we, adr, dat, sel are broadcast
        .stb_i   (dmem_stb),
        .we_i    (wb_we_i),
        .adr_i   (wb_adr_i),
        .dat_i   (wb_dat_i),
        .sel_i   (wb_sel_i),
        .dat_o   (dmem_dat),
        .ack_o   (dmem_ack)
    );

    wb_latency_ram #(
        .MEM_BYTES (`WB_XIO_BYTES),
        .LATENCY   (`WB_XIO_LATENCY)
    ) xio_i (
        .clk_gen (clk_gen),
        .rst_gen (rst_gen),
        .cyc_i   (wb_cyc_i),
        .stb_i   (xio_stb),
        .we_i    (wb_we_i),
        .adr_i   (wb_adr_i),
        .dat_i   (wb_dat_i),
        .sel_i   (wb_sel_i),
        .dat_o   (xio_dat),
        .ack_o   (xio_ack)
    );

    // interrupt trigger -------------
    wb_irq_trigger irq_i (
        .clk_gen    (clk_gen),
        .rst_gen    (rst_gen),
        .cyc_i      (wb_cyc_i),
        .stb_i      (irq_stb),
        .we_i       (wb_we_i),
        .sel_i      (wb_sel_i),
        .dat_i      (wb_dat_i),
        .dat_o      (irq_dat),
        .ack_o      (irq_ack),
        .msw_irq_o  (msw_irq_o),
        .mext_irq_o (mext_irq_o)
    );

endmodule : wb_sim_target_top

`default_nettype wire

//--- sim/wb_sim_target_chk.sv
/*
 * Protocol checker for the simulated Wishbone target.
 * Bound to the top level, sampled on the falling clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module wb_sim_target_chk (
    input logic                 clk_gen,
    input logic                 rst_gen,
    input logic                 cyc_i,       // master cycle
    input logic                 ack_i,       // target acknowledge
    input wb_sim_pkg::wb_data_t dat_i,       // target read data
    input logic                 msw_irq_i,
    input logic                 mext_irq_i
);
    int fail_cnt = 0;  // failed assertions so far

    // registered outputs are settled half a cycle after the rising edge
    ack_in_cycle: assert property (@(negedge clk_gen) disable iff (!rst_gen)
        ack_i |-> cyc_i)
        else begin $error("ack high outside a bus cycle"); fail_cnt++; end

    data_idle_zero: assert property (@(negedge clk_gen) disable iff (!rst_gen)
        !ack_i |-> (dat_i == '0))
        else begin $error("read data not zero while ack is low"); fail_cnt++; end

    ack_one_cycle: assert property (@(negedge clk_gen) disable iff (!rst_gen)
        ack_i |=> !ack_i)
        else begin $error("ack held for two cycles"); fail_cnt++; end

    irq_reset_low: assert property (@(negedge clk_gen)
        !rst_gen |-> (!msw_irq_i && !mext_irq_i))
        else begin $error("interrupt line high during reset"); fail_cnt++; end

endmodule : wb_sim_target_chk

bind wb_sim_target_top wb_sim_target_chk chk_i (
    .clk_gen    (clk_gen),
    .rst_gen    (rst_gen),
    .cyc_i      (wb_cyc_i),
    .ack_i      (wb_ack_o),
    .dat_i      (wb_dat_o),
    .msw_irq_i  (msw_irq_o),
    .mext_irq_i (mext_irq_o)
);

`default_nettype wire

//--- sim/wb_sim_target_tb.sv
/*
 * Testbench for the simulated Wishbone classic target.
 * Random master with a byte-level model of both RAM windows,
 * trigger word writes and requests that must never be answered.
 */
`timescale 1ns/1ps
`default_nettype none

`include "wb_sim_cfg.svh"

module wb_sim_target_tb;
    import wb_sim_pkg::*;

    localparam int TIMEOUT  = 300;  // cycles before a wait gives up
    localparam int DMEM_OPS = 80;
    localparam int XIO_OPS  = 24;   // slow window, fewer ops
    localparam int IRQ_OPS  = 8;

    logic     clk_gen;
    logic     rst_gen;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_addr_t wb_adr_i;
    wb_data_t wb_dat_i;
    wb_sel_t  wb_sel_i;
    wb_data_t wb_dat_o;
    logic     wb_ack_o;
    logic     msw_irq_o;
    logic     mext_irq_o;

    // reference model, one byte and one written flag per location
    logic [7:0] dmem_byte [`WB_DMEM_BYTES];
    bit         dmem_set  [`WB_DMEM_BYTES];
    logic [7:0] xio_byte  [`WB_XIO_BYTES];
    bit         xio_set   [`WB_XIO_BYTES];

    wb_sim_target_top wb_sim_target_top_i (
        .clk_gen    (clk_gen),
        .rst_gen    (rst_gen),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .msw_irq_o  (msw_irq_o),
        .mext_irq_o (mext_irq_o)
    );

    always #10 clk_gen = ~clk_gen;  // 20 ns period

    // error handling ----------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("MISMATCH at %0t ns: %s = 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
    endtask

    // bus master --------------------
    // called on a falling edge, returns on a falling edge after one idle cycle
    task automatic bus_transfer(input logic we, input wb_addr_t adr, input wb_data_t dat,
                                input wb_sel_t sel, input int exp_lat,
                                output wb_data_t rdat);
        int   cycles;
        logic acked;
        cycles   = 0;
        acked    = 1'b0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_sel_i = sel;
        while (!acked && cycles < TIMEOUT) begin
            @(negedge clk_gen);
            cycles++;                   // first negedge follows the sampling edge
            acked = wb_ack_o;
        end
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;                // withdraw right after the ack
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        assert (acked) else
            abort_run($sformatf("no acknowledge within %0d cycles for address 0x%08h",
                                TIMEOUT, adr));
        compare_word("ack latency", cycles - 1, exp_lat);
        @(negedge clk_gen);             // bus idle for one cycle
    endtask

    // request nobody accepts, held for the whole timeout then withdrawn
    task automatic expect_no_ack(input logic we, input wb_addr_t adr, input wb_data_t dat,
                                 input wb_sel_t sel);
        logic msw_before;
        logic mext_before;
        msw_before  = msw_irq_o;
        mext_before = mext_irq_o;
        wb_cyc_i    = 1'b1;
        wb_stb_i    = 1'b1;
        wb_we_i     = we;
        wb_adr_i    = adr;
        wb_dat_i    = dat;
        wb_sel_i    = sel;
        for (int c = 0; c < TIMEOUT; c++) begin
            @(negedge clk_gen);
            assert (!wb_ack_o) else
                abort_run($sformatf("acknowledge seen for unanswerable request to 0x%08h",
                                    adr));
            compare_word("wb_dat_o", wb_dat_o, '0);
            compare_word("msw_irq_o", msw_irq_o, msw_before);
            compare_word("mext_irq_o", mext_irq_o, mext_before);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        @(negedge clk_gen);
    endtask

    // reference model ---------------
    task automatic model_write(input bit is_xio, input int offset, input wb_data_t dat,
                               input wb_sel_t sel);
        for (int b = 0; b < 4; b++) begin
            if (sel[b] && is_xio) begin
                xio_byte[offset+b] = dat[b*8 +: 8];
                xio_set[offset+b]  = 1'b1;
            end else if (sel[b]) begin
                dmem_byte[offset+b] = dat[b*8 +: 8];
                dmem_set[offset+b]  = 1'b1;
            end
        end
    endtask

    task automatic model_read(input bit is_xio, input int offset, output wb_data_t word,
                              output bit known);
        known = 1'b1;
        word  = '0;
        for (int b = 0; b < 4; b++) begin
            word[b*8 +: 8] = is_xio ? xio_byte[offset+b] : dmem_byte[offset+b];
            known          = known & (is_xio ? xio_set[offset+b] : dmem_set[offset+b]);
        end
    endtask

    // random traffic to one RAM window
    task automatic run_window(input bit is_xio, input int n_ops);
        wb_addr_t base;
        int       lat;
        int       offset;
        logic     we;
        wb_sel_t  sel;
        wb_data_t dat;
        wb_data_t rdat;
        wb_data_t exp;
        bit       known;
        base = is_xio ? `WB_XIO_BASE : `WB_DMEM_BASE;
        lat  = is_xio ? `WB_XIO_LATENCY : `WB_DMEM_LATENCY;
        for (int i = 0; i < n_ops; i++) begin
            // 16 hot words spread over the data memory so reads hit written words
            offset = is_xio ? ($urandom % (`WB_XIO_BYTES / 4)) * 4 : ($urandom % 16) * 508;
            we     = $urandom % 2;
            sel    = we ? wb_sel_t'(($urandom % 15) + 1) : 4'hF;
            dat    = $urandom;
            bus_transfer(we, base + wb_addr_t'(offset), dat, sel, lat, rdat);
            if (we) begin
                model_write(is_xio, offset, dat, sel);
            end else begin
                model_read(is_xio, offset, exp, known);
                if (known) begin
                    compare_word(is_xio ? "wb_dat_o (xio)" : "wb_dat_o (dmem)", rdat, exp);
                end
            end
        end
    endtask

    // main sequence -----------------
    initial begin
        wb_data_t dat;
        wb_data_t rdat;
        clk_gen  = 1'b0;
        rst_gen  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_sel_i = '0;
        void'($urandom(20109));
        repeat (4) @(posedge clk_gen);
        @(negedge clk_gen);
        rst_gen = 1'b1;
        @(negedge clk_gen);
        compare_word("wb_ack_o", wb_ack_o, 0);
        compare_word("wb_dat_o", wb_dat_o, 0);
        compare_word("msw_irq_o", msw_irq_o, 0);
        compare_word("mext_irq_o", mext_irq_o, 0);
        run_window(1'b0, DMEM_OPS);
        run_window(1'b1, XIO_OPS);
        for (int i = 0; i < IRQ_OPS; i++) begin
            dat = $urandom;
            bus_transfer(1'b1, `WB_IRQ_ADDR, dat, 4'hF, 1, rdat);
            compare_word("msw_irq_o", msw_irq_o, dat[`WB_MSI_BIT]);
            compare_word("mext_irq_o", mext_irq_o, dat[`WB_MEI_BIT]);
        end
        // trigger bits opposite to the lines, so a wrong latch shows up
        dat              = $urandom;
        dat[`WB_MSI_BIT] = ~msw_irq_o;
        dat[`WB_MEI_BIT] = ~mext_irq_o;
        expect_no_ack(1'b1, `WB_IRQ_ADDR, dat, wb_sel_t'($urandom % 15));      // partial
        expect_no_ack(1'b0, `WB_IRQ_ADDR, '0, 4'hF);                           // read
        expect_no_ack($urandom % 2, 32'h4000_0000 | ($urandom & 32'h00FF_FFFC),
                      $urandom, 4'hF);                                         // unmapped
        if (wb_sim_target_top_i.chk_i.fail_cnt != 0) begin
            abort_run("bus protocol checker reported assertion failures");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule : wb_sim_target_tb

`default_nettype wire

//--- sources.f
+incdir+hw
hw/wb_sim_pkg.sv
hw/wb_addr_decode.sv
hw/wb_latency_ram.sv
hw/wb_irq_trigger.sv
hw/wb_sim_target_top.sv
sim/wb_sim_target_chk.sv
sim/wb_sim_target_tb.sv

//--- Bender.yml
package:
  name: wb_sim_target

sources:
  - include_dirs:
      - hw
    files:
      - hw/wb_sim_pkg.sv
      - hw/wb_addr_decode.sv
      - hw/wb_latency_ram.sv
      - hw/wb_irq_trigger.sv
      - hw/wb_sim_target_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/wb_sim_target_chk.sv
      - sim/wb_sim_target_tb.sv
